// File: logic/motor_pkg.sv
package motor_pkg;

	// Requested state of one phase, also used as its gate pair {high gate, low gate}
	// The forbidden request with both bits set is treated as off by the bridge
	typedef enum logic [1:0] {
		phase_off  = 2'b00,
		phase_low  = 2'b01,
		phase_high = 2'b10,
		phase_noff = 2'b11
	} bridge_state_t;

	// Drive mode chosen by the host for the whole bridge
	typedef enum logic [1:0] {
		mode_coast      = 2'b00,
		mode_slow_decay = 2'b01,
		mode_fast_drive = 2'b10,
		mode_fast_brake = 2'b11
	} drive_mode_t;

	// Width of the PWM phase counter, so one period is 128 phase steps
	localparam int pwm_phase_bits = 7;

	// Duty level compared against the phase, 0 keeps the high side off
	typedef logic [pwm_phase_bits-1:0] pwm_level_t;

	// Free-running position inside one PWM period
	typedef logic [pwm_phase_bits-1:0] pwm_phase_t;

	// Hall codes that no healthy sensor set can produce
	// All sensors low usually means a lost supply, all high a broken pull-up
	localparam logic [2:0] hall_all_low  = 3'b000;
	localparam logic [2:0] hall_all_high = 3'b111;

	// One-hot phase masks used by the six-step table, ordered {C, B, A}
	localparam logic [2:0] phase_sel_a = 3'b001;
	localparam logic [2:0] phase_sel_b = 3'b010;
	localparam logic [2:0] phase_sel_c = 3'b100;

	// Empty mask for the invalid codes
	localparam logic [2:0] phase_sel_none = 3'b000;

endpackage

// File: logic/pwm_generator.sv
`timescale 1ns/100ps

module pwm_generator
	import motor_pkg::*;
#(
	parameter int pwm_div   = 1,
	parameter int dead_time = 3
) (
	input  logic       clk,
	input  logic       rst,
	input  pwm_level_t level,
	output logic       period_start,
	output logic       pwm_high,
	output logic       pwm_low
);

	// The divider needs at least one bit even when every clock is a phase step
	localparam int div_bits = (pwm_div > 1) ? $clog2(pwm_div) : 1;
	localparam logic [div_bits-1:0] div_last = div_bits'(pwm_div - 1);

	// Dead time widened by one bit to match the threshold below
	localparam logic [pwm_phase_bits:0] dead_steps = dead_time[pwm_phase_bits:0];

	logic [div_bits-1:0]     div_count;
	pwm_phase_t              phase;
	logic [pwm_phase_bits:0] low_threshold;

	// Clock divider and phase counter
	// The phase wraps from 127 back to 0 on its own
	always_ff @(posedge clk) begin
		if (rst) begin
			div_count <= '0;
			phase     <= '0;
		end else if (div_count == div_last) begin
			div_count <= '0;
			phase     <= phase + 1'b1;
		end else begin
			div_count <= div_count + 1'b1;
		end
	end

	// One cycle strobe at the very first clock of each period
	assign period_start = (phase == '0) && (div_count == '0);

	// The extra top bit keeps a large level plus dead time from wrapping
	// Once the sum passes 127 the low window simply never opens
	assign low_threshold = {1'b0, level} + dead_steps;

	// Both windows are registered so the gates see clean edges
	always_ff @(posedge clk) begin
		if (rst) begin
			pwm_high <= 1'b0;
			pwm_low  <= 1'b0;
		end else begin
			pwm_high <= (phase < level);
			pwm_low  <= ({1'b0, phase} >= low_threshold);
		end
	end

endmodule

// File: logic/motor_regs.sv
`timescale 1ns/100ps

module motor_regs
	import motor_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        cmd_valid,
	output logic        cmd_ready,
	input  logic        cmd_direction,
	input  pwm_level_t  cmd_level,
	input  drive_mode_t cmd_mode,
	input  logic        period_start,
	output logic        direction,
	output pwm_level_t  level,
	output drive_mode_t mode
);

	// Shadow copy of the last accepted command
	logic        shadow_direction;
	pwm_level_t  shadow_level;
	drive_mode_t shadow_mode;

	// Set while the shadow holds a command that is not active yet
	logic pending;

	logic transfer;

	// The port only takes a new command once the previous one is active
	assign cmd_ready = !pending;
	assign transfer  = cmd_valid && cmd_ready;

	// Shadow capture on a transfer
	always_ff @(posedge clk) begin
		if (transfer) begin
			shadow_direction <= cmd_direction;
			shadow_level     <= cmd_level;
			shadow_mode      <= cmd_mode;
		end
	end

	// Pending flag
	// A transfer that meets a strobe with nothing pending waits for the next boundary
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (transfer) begin
			pending <= 1'b1;
		end else if (period_start) begin
			pending <= 1'b0;
		end
	end

	// Active settings only change at a period boundary
	// That way the duty and the mode never switch halfway through a PWM period
	always_ff @(posedge clk) begin
		if (rst) begin
			direction <= 1'b0;
			level     <= '0;
			mode      <= mode_coast;
		end else if (period_start && pending) begin
			direction <= shadow_direction;
			level     <= shadow_level;
			mode      <= shadow_mode;
		end
	end

endmodule

// File: logic/hall_commutator.sv
`timescale 1ns/100ps

module hall_commutator
	import motor_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic [2:0]    hall,
	input  logic          direction,
	output bridge_state_t phase_a,
	output bridge_state_t phase_b,
	output bridge_state_t phase_c,
	output logic          fault
);

	// Two flop synchronizer for the asynchronous sensor lines
	logic [2:0] hall_meta;
	logic [2:0] hall_sync;

	// Phases that the current hall code wants high and low, as {C, B, A} masks
	logic [2:0] fwd_high;
	logic [2:0] fwd_low;
	logic [2:0] sel_high;
	logic [2:0] sel_low;
	logic       invalid;

	// Reset is left off here since the flops fill up during the reset cycles anyway
	always_ff @(posedge clk) begin
		hall_meta <= hall;
		hall_sync <= hall_meta;
	end

	// Six-step table for forward rotation
	always_comb begin
		case (hall_sync)
			3'b001:  begin fwd_high = phase_sel_a; fwd_low = phase_sel_b; end
			3'b011:  begin fwd_high = phase_sel_a; fwd_low = phase_sel_c; end
			3'b010:  begin fwd_high = phase_sel_b; fwd_low = phase_sel_c; end
			3'b110:  begin fwd_high = phase_sel_b; fwd_low = phase_sel_a; end
			3'b100:  begin fwd_high = phase_sel_c; fwd_low = phase_sel_a; end
			3'b101:  begin fwd_high = phase_sel_c; fwd_low = phase_sel_b; end
			default: begin fwd_high = phase_sel_none; fwd_low = phase_sel_none; end
		endcase
	end

	// Reverse rotation drives the same pair with the current flowing the other way
	assign sel_high = direction ? fwd_low : fwd_high;
	assign sel_low  = direction ? fwd_high : fwd_low;

	assign invalid = (hall_sync == hall_all_low) || (hall_sync == hall_all_high);

	// Map one phase's share of the masks onto a bridge state
	function automatic bridge_state_t phase_state(input logic want_high, input logic want_low);
		bridge_state_t result;
		if (want_high) begin
			result = phase_high;
		end else if (want_low) begin
			result = phase_low;
		end else begin
			result = phase_off;
		end
		return result;
	endfunction

	// Registered decode, an invalid code opens every phase
	// The table already returns empty masks there, the fault just makes it visible
	always_ff @(posedge clk) begin
		if (rst) begin
			phase_a <= phase_off;
			phase_b <= phase_off;
			phase_c <= phase_off;
			fault   <= 1'b0;
		end else begin
			phase_a <= phase_state(sel_high[0], sel_low[0]);
			phase_b <= phase_state(sel_high[1], sel_low[1]);
			phase_c <= phase_state(sel_high[2], sel_low[2]);
			fault   <= invalid;
		end
	end

endmodule

// File: logic/half_bridge.sv
`timescale 1ns/100ps

module half_bridge
	import motor_pkg::*;
(
	input  bridge_state_t state,
	input  drive_mode_t   mode,
	input  logic          pwm_high,
	input  logic          pwm_low,
	output bridge_state_t gate
);

	// A request for both switches at once is never passed on
	bridge_state_t clean_state;

	// Set when the commutator uses this phase in the current step
	logic driven;

	// Low side for a driven phase, open for the floating one
	bridge_state_t brake_state;

	assign clean_state = (state == phase_noff) ? phase_off : state;
	assign driven      = (clean_state != phase_off);
	assign brake_state = driven ? phase_low : phase_off;

	always_comb begin
		case (mode)
			// Everything open, the motor spins down freely
			mode_coast: begin
				gate = phase_off;
			end
			// Drive during the high window and recirculate through the low sides
			// The gap between the two windows is the dead time
			mode_slow_decay: begin
				if (pwm_high) begin
					gate = clean_state;
				end else if (pwm_low) begin
					gate = brake_state;
				end else begin
					gate = phase_off;
				end
			end
			// Drive during the high window, current decays through the body diodes
			mode_fast_drive: begin
				gate = pwm_high ? clean_state : phase_off;
			end
			// Short the driven windings to ground for the high window
			mode_fast_brake: begin
				gate = pwm_high ? brake_state : phase_off;
			end
			default: begin
				gate = phase_off;
			end
		endcase
	end

endmodule

// File: logic/motor_drive_top.sv
`timescale 1ns/100ps

module motor_drive_top
	import motor_pkg::*;
#(
	parameter int pwm_div   = 1,
	parameter int dead_time = 3
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        cmd_valid,
	output logic        cmd_ready,
	input  logic        cmd_direction,
	input  pwm_level_t  cmd_level,
	input  drive_mode_t cmd_mode,
	input  logic [2:0]  hall,
	output logic [5:0]  motor_out,
	output logic        fault
);

	// Active settings from the register block
	logic        direction;
	pwm_level_t  level;
	drive_mode_t mode;

	// PWM timing
	logic period_start;
	logic pwm_high;
	logic pwm_low;

	// Requested state per phase from the commutator
	bridge_state_t phase_a;
	bridge_state_t phase_b;
	bridge_state_t phase_c;

	motor_regs u_motor_regs (
		.clk           (clk),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd_direction (cmd_direction),
		.cmd_level     (cmd_level),
		.cmd_mode      (cmd_mode),
		.period_start  (period_start),
		.direction     (direction),
		.level         (level),
		.mode          (mode)
	);

	pwm_generator #(
		.pwm_div   (pwm_div),
		.dead_time (dead_time)
	) u_pwm_generator (
		.clk          (clk),
		.rst          (rst),
		.level        (level),
		.period_start (period_start),
		.pwm_high     (pwm_high),
		.pwm_low      (pwm_low)
	);

	hall_commutator u_hall_commutator (
		.clk       (clk),
		.rst       (rst),
		.hall      (hall),
		.direction (direction),
		.phase_a   (phase_a),
		.phase_b   (phase_b),
		.phase_c   (phase_c),
		.fault     (fault)
	);

	// One bridge per phase, each gate pair lands in its own slice of motor_out
	half_bridge u_bridge_a (
		.state    (phase_a),
		.mode     (mode),
		.pwm_high (pwm_high),
		.pwm_low  (pwm_low),
		.gate     (motor_out[1:0])
	);

	half_bridge u_bridge_b (
		.state    (phase_b),
		.mode     (mode),
		.pwm_high (pwm_high),
		.pwm_low  (pwm_low),
		.gate     (motor_out[3:2])
	);

	half_bridge u_bridge_c (
		.state    (phase_c),
		.mode     (mode),
		.pwm_high (pwm_high),
		.pwm_low  (pwm_low),
		.gate     (motor_out[5:4])
	);

endmodule

// File: tests/motor_drive_assertions.sv
`timescale 1ns/100ps

module motor_drive_assertions (
	input logic       clk,
	input logic       rst,
	input logic       cmd_valid,
	input logic       cmd_ready,
	input logic       period_start,
	input logic [5:0] motor_out,
	input logic       fault
);

	// A phase with both switches closed shorts the supply
	phase_a_safe: assert property (@(posedge clk) disable iff (rst)
		!(motor_out[1] && motor_out[0]))
		else $error("phase A drives both gates");
	phase_b_safe: assert property (@(posedge clk) disable iff (rst)
		!(motor_out[3] && motor_out[2]))
		else $error("phase B drives both gates");
	phase_c_safe: assert property (@(posedge clk) disable iff (rst)
		!(motor_out[5] && motor_out[4]))
		else $error("phase C drives both gates");

	// An accepted command blocks the port on the next cycle
	ready_drops: assert property (@(posedge clk) disable iff (rst)
		(cmd_valid && cmd_ready) |=> !cmd_ready)
		else $error("cmd_ready still high after a transfer");

	// Only a period boundary releases a pending update
	ready_holds: assert property (@(posedge clk) disable iff (rst)
		(!cmd_ready && !period_start) |=> !cmd_ready)
		else $error("cmd_ready rose without a period boundary");

	// A bad hall code opens every switch
	fault_off: assert property (@(posedge clk) disable iff (rst)
		fault |-> (motor_out == 6'b000000))
		else $error("gates active while fault is set");

endmodule

bind motor_drive_top motor_drive_assertions u_motor_drive_assertions (
	.clk          (clk),
	.rst          (rst),
	.cmd_valid    (cmd_valid),
	.cmd_ready    (cmd_ready),
	.period_start (period_start),
	.motor_out    (motor_out),
	.fault        (fault)
);

// File: tests/motor_drive_tb.sv
`timescale 1ns/100ps

module motor_drive_tb
	import motor_pkg::*;
();

	localparam int pwm_div   = 1;
	localparam int dead_time = 3;

	// Longest wait for a boundary or for the port is one full period plus some slack
	localparam int wait_limit = 128 * pwm_div + 16;

	// One table entry holds the stimulus first and then what the period after it must show
	// Counts are indexed by phase with A at index 0
	typedef struct packed {
		logic [2:0]      hall;
		logic            direction;
		pwm_level_t      level;
		drive_mode_t     mode;
		logic [2:0][7:0] high_count;
		logic [2:0][7:0] low_count;
		logic            fault;
	} row_t;

	logic        clk;
	logic        rst;
	logic        cmd_valid;
	logic        cmd_ready;
	logic        cmd_direction;
	pwm_level_t  cmd_level;
	drive_mode_t cmd_mode;
	logic [2:0]  hall;
	logic [5:0]  motor_out;
	logic        fault;

	// Period strobe seen from inside the DUT paces the stimulus
	logic period_boundary;

	logic [31:0] lcg_state;
	logic [2:0]  valid_codes [6];
	row_t        rows [$];

	motor_drive_top #(
		.pwm_div   (pwm_div),
		.dead_time (dead_time)
	) u_motor_drive_top (
		.clk           (clk),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd_direction (cmd_direction),
		.cmd_level     (cmd_level),
		.cmd_mode      (cmd_mode),
		.hall          (hall),
		.motor_out     (motor_out),
		.fault         (fault)
	);

	assign period_boundary = u_motor_drive_top.period_start;

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Plain LCG whose upper bits are the useful ones
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Six-step table written out per hall code
	// Reverse swaps the high and low phase
	function automatic bridge_state_t commutation_state(input logic [2:0] code,
			input logic reverse, input int ph);
		int high_ph;
		int low_ph;
		int spare;
		bridge_state_t result;
		case (code)
			3'b001: begin high_ph = 0; low_ph = 1; end
			3'b011: begin high_ph = 0; low_ph = 2; end
			3'b010: begin high_ph = 1; low_ph = 2; end
			3'b110: begin high_ph = 1; low_ph = 0; end
			3'b100: begin high_ph = 2; low_ph = 0; end
			3'b101: begin high_ph = 2; low_ph = 1; end
			default: begin high_ph = -1; low_ph = -1; end
		endcase
		if (reverse) begin
			spare   = high_ph;
			high_ph = low_ph;
			low_ph  = spare;
		end
		if (ph == high_ph) begin
			result = phase_high;
		end else if (ph == low_ph) begin
			result = phase_low;
		end else begin
			result = phase_off;
		end
		return result;
	endfunction

	// Gate pair expected at one phase step of the period
	function automatic bridge_state_t gate_model(input bridge_state_t state,
			input drive_mode_t mode, input pwm_level_t level, input int step);
		bridge_state_t cleaned;
		bridge_state_t result;
		logic high_on;
		logic low_on;
		cleaned = (state == phase_noff) ? phase_off : state;
		high_on = (step < int'(level));
		// Low window opens dead_time steps after the high window closes
		low_on  = (step >= int'(level) + dead_time);
		result  = phase_off;
		case (mode)
			mode_slow_decay: begin
				if (high_on) begin
					result = cleaned;
				end else if (low_on && cleaned != phase_off) begin
					result = phase_low;
				end
			end
			mode_fast_drive: begin
				if (high_on) begin
					result = cleaned;
				end
			end
			mode_fast_brake: begin
				if (high_on && cleaned != phase_off) begin
					result = phase_low;
				end
			end
			default: begin
				result = phase_off;
			end
		endcase
		return result;
	endfunction

	function automatic row_t make_row(input logic [2:0] code, input logic reverse,
			input pwm_level_t level, input drive_mode_t mode);
		row_t row;
		bridge_state_t gate;
		int highs;
		int lows;
		int ph;
		int step;
		row.hall      = code;
		row.direction = reverse;
		row.level     = level;
		row.mode      = mode;
		row.fault     = (code == 3'b000) || (code == 3'b111);
		for (ph = 0; ph < 3; ph++) begin
			highs = 0;
			lows  = 0;
			for (step = 0; step < 128; step++) begin
				gate = gate_model(commutation_state(code, reverse, ph), mode, level, step);
				if (gate[1]) highs++;
				if (gate[0]) lows++;
			end
			row.high_count[ph] = 8'(highs);
			row.low_count[ph]  = 8'(lows);
		end
		return row;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "testbench stopped on the first error");
	endtask

	task automatic check_gate(input string name, input bridge_state_t expected,
			input bridge_state_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("error at time %0t: %s expected %b, got %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input integer expected, input integer actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("error at time %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("error at time %0t: %s expected %b, got %b",
				$time, name, expected, actual));
		end
	endtask

	// Holds the command on the port until it transfers
	// Reports whether a period boundary went by while the port was busy
	task automatic present_command(input logic direction, input pwm_level_t level,
			input drive_mode_t mode, output logic boundary_seen);
		int waited;
		cmd_valid     = 1'b1;
		cmd_direction = direction;
		cmd_level     = level;
		cmd_mode      = mode;
		boundary_seen = 1'b0;
		waited        = 0;
		while (!cmd_ready) begin
			if (period_boundary) boundary_seen = 1'b1;
			@(posedge clk);
			#2;
			waited++;
			if (waited > wait_limit) begin
				stop_with_failure("timeout: cmd_ready did not return within one PWM period");
			end
		end
		// The transfer happens on this edge
		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
	endtask

	// Returns just after the edge on which the strobe was high
	task automatic wait_boundary();
		int waited;
		waited = 0;
		while (!period_boundary) begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > wait_limit) begin
				stop_with_failure("timeout: no PWM period boundary seen");
			end
		end
		@(posedge clk);
		#2;
	endtask

	// Counts the gates over one whole period at the falling edges, step 0 first
	// The first and the last step pin down where the windows sit inside the period
	task automatic sample_period(input row_t row);
		int high_seen [3];
		int low_seen [3];
		bridge_state_t actual;
		bridge_state_t expected;
		int ph;
		int step;
		for (ph = 0; ph < 3; ph++) begin
			high_seen[ph] = 0;
			low_seen[ph]  = 0;
		end
		for (step = 0; step < 128; step++) begin
			@(negedge clk);
			check_bit("fault", row.fault, fault);
			for (ph = 0; ph < 3; ph++) begin
				actual = bridge_state_t'(motor_out[2*ph +: 2]);
				if (step == 0 || step == 127) begin
					expected = gate_model(commutation_state(row.hall, row.direction, ph),
						row.mode, row.level, step);
					check_gate($sformatf("motor_out phase %0d gate at step %0d", ph, step),
						expected, actual);
				end
				if (actual[1]) high_seen[ph]++;
				if (actual[0]) low_seen[ph]++;
			end
		end
		for (ph = 0; ph < 3; ph++) begin
			check_count($sformatf("phase %0d high gate count", ph),
				int'(row.high_count[ph]), high_seen[ph]);
			check_count($sformatf("phase %0d low gate count", ph),
				int'(row.low_count[ph]), low_seen[ph]);
		end
		@(posedge clk);
		#2;
	endtask

	initial begin
		logic [31:0] rnd;
		logic        boundary_seen;
		row_t        row;
		row_t        second;
		int          i;
		int          d;
		rst           = 1'b1;
		cmd_valid     = 1'b0;
		cmd_direction = 1'b0;
		cmd_level     = '0;
		cmd_mode      = mode_coast;
		hall          = 3'b001;
		lcg_state     = 32'h2a58f8bf;
		valid_codes   = '{3'b001, 3'b011, 3'b010, 3'b110, 3'b100, 3'b101};
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		check_bit("cmd_ready", 1'b1, cmd_ready);
		check_bit("fault", 1'b0, fault);

		// Every valid hall code in both directions at half duty
		for (d = 0; d < 2; d++) begin
			for (i = 0; i < 6; i++) begin
				rows.push_back(make_row(valid_codes[i], 1'(d), 7'd64, mode_fast_drive));
			end
		end
		// Slow decay across the duty range
		// The top end closes the low window
		rows.push_back(make_row(3'b001, 1'b0, 7'd0, mode_slow_decay));
		rows.push_back(make_row(3'b010, 1'b1, 7'd100, mode_slow_decay));
		rows.push_back(make_row(3'b110, 1'b0, 7'd127, mode_slow_decay));
		rows.push_back(make_row(3'b101, 1'b1, 7'd37, mode_slow_decay));
		rows.push_back(make_row(3'b100, 1'b0, 7'd90, mode_fast_brake));
		rows.push_back(make_row(3'b011, 1'b0, 7'd80, mode_coast));
		// Invalid codes followed by recovery on a valid one
		rows.push_back(make_row(3'b000, 1'b0, 7'd70, mode_fast_drive));
		rows.push_back(make_row(3'b111, 1'b1, 7'd70, mode_slow_decay));
		rows.push_back(make_row(3'b010, 1'b0, 7'd50, mode_fast_drive));
		for (i = 0; i < 6; i++) begin
			rnd = next_random();
			rows.push_back(make_row(valid_codes[int'(rnd[19:16]) % 6], rnd[21],
				rnd[31:25], drive_mode_t'(rnd[23:22])));
		end

		for (i = 0; i < rows.size(); i++) begin
			row = rows[i];
			present_command(row.direction, row.level, row.mode, boundary_seen);
			check_bit("cmd_ready", 1'b0, cmd_ready);
			hall = row.hall;
			wait_boundary();
			wait_boundary();
			sample_period(row);
		end

		// In back-to-back commands the second one has to sit out the first boundary
		row    = make_row(3'b011, 1'b0, 7'd20, mode_fast_drive);
		second = make_row(3'b011, 1'b0, 7'd90, mode_slow_decay);
		hall   = row.hall;
		present_command(row.direction, row.level, row.mode, boundary_seen);
		check_bit("cmd_ready", 1'b0, cmd_ready);
		present_command(second.direction, second.level, second.mode, boundary_seen);
		if (!boundary_seen) begin
			stop_with_failure("cmd_ready rose again before any PWM period boundary");
		end
		check_bit("cmd_ready", 1'b0, cmd_ready);
		wait_boundary();
		wait_boundary();
		sample_period(second);

		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: filelist.f
logic/motor_pkg.sv
logic/pwm_generator.sv
logic/motor_regs.sv
logic/hall_commutator.sv
logic/half_bridge.sv
logic/motor_drive_top.sv
tests/motor_drive_assertions.sv
tests/motor_drive_tb.sv

// File: run.sh
#!/bin/sh
# Build the simulator from the file list, run it and look for the pass line in its output
verilator --binary --timing --assert --top-module motor_drive_tb -f filelist.f &&
./obj_dir/Vmotor_drive_tb | tee /dev/stderr | grep -q "^=== PASS ===$" &&
echo "motor_drive: simulation passed" ||
{ echo "motor_drive: simulation failed"; exit 1; }
